//--- src/cache_pkg.sv
package cache_pkg;

	localparam int addr_w = 32;
	localparam int word_w = 32;
	localparam int bytes_per_word = 4;
	localparam int words_per_line = 4;
	localparam int offset_w = 4;		// byte + word offset
	localparam int beat_w = 16;
	localparam int beats_per_line = word_w * words_per_line / beat_w;
	localparam int ways = 2;
	localparam int word_sel_w = $clog2(words_per_line);
	localparam int line_addr_w = addr_w - offset_w;

	// tag field sized for the smallest index
	localparam int min_set_bits = 2;
	localparam int tag_w = addr_w - offset_w - min_set_bits;

	typedef logic [word_w-1:0] word_t;
	typedef logic [tag_w-1:0] tag_t;

	// word 0 sits in the top bits, beat 0 is its high half
	typedef union packed {
		word_t [0:words_per_line-1] words;
		logic [0:beats_per_line-1][beat_w-1:0] beats;
	} line_u;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} way_flags_t;

	typedef struct packed {
		way_flags_t [ways-1:0] way;
		logic lru;		// next victim
	} set_flags_t;

	typedef line_u [ways-1:0] set_line_t;
	typedef logic [ways-1:0][0:words_per_line-1][bytes_per_word-1:0] set_be_t;

	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_done,
		st_evict,
		st_fill,
		st_reread
	} ctrl_state_e;

endpackage

//--- src/set_port_if.sv
`timescale 1ns/1ns

interface set_port_if #(
	parameter int set_bits = 4
);
	logic en;
	logic rd;
	logic wr_data;
	logic wr_flag;
	logic [set_bits-1:0] index;
	cache_pkg::set_flags_t flag_in;
	cache_pkg::set_line_t line_in;
	cache_pkg::set_be_t byte_en;
	cache_pkg::set_flags_t flag_out;		// valid one cycle after en && rd
	cache_pkg::set_line_t line_out;

	modport store (
		input en, rd, wr_data, wr_flag, index, flag_in, line_in, byte_en,
		output flag_out, line_out
	);
	modport ctrl (output en, rd, wr_data, wr_flag);
	modport merge (output flag_in, line_in, byte_en, input flag_out, line_out);
	modport decode (output index, input flag_out);

endinterface

//--- src/lookup_if.sv
`timescale 1ns/1ns

interface lookup_if;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic [cache_pkg::line_addr_w-1:0] victim_line_addr;
	logic [cache_pkg::line_addr_w-1:0] fill_line_addr;
	cache_pkg::tag_t tag;
	logic [cache_pkg::word_sel_w-1:0] word_sel;

	modport driver (
		output hit, hit_way, victim_way, victim_dirty,
		output victim_line_addr, fill_line_addr, tag, word_sel
	);
	modport reader (
		input hit, hit_way, victim_way, victim_dirty,
		input victim_line_addr, fill_line_addr, tag, word_sel
	);

endinterface

//--- src/set_store.sv
`timescale 1ns/1ns

module set_store #(
	parameter int set_bits = 4
) (
	input logic clk_50m,
	input logic rst_n,
	set_port_if.store port
);

	localparam int sets = 2 ** set_bits;
	localparam int line_bytes = $bits(cache_pkg::set_line_t) / 8;

	cache_pkg::set_flags_t flag_mem [sets];
	logic [8*line_bytes-1:0] line_mem [sets];
	logic [8*line_bytes-1:0] line_wr;
	logic [line_bytes-1:0] be_wr;

	assign line_wr = port.line_in;		// flat byte view
	assign be_wr = port.byte_en;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < sets; i++)
				flag_mem[i] <= '0;
			port.flag_out <= '0;
		end else begin
			if (port.en && port.wr_flag)
				flag_mem[port.index] <= port.flag_in;
			if (port.en && port.rd)
				port.flag_out <= flag_mem[port.index];
		end
	end

	always_ff @(posedge clk_50m) begin
		if (port.en && port.wr_data) begin
			for (int b = 0; b < line_bytes; b++)
				if (be_wr[b])
					line_mem[port.index][8*b +: 8] <= line_wr[8*b +: 8];
		end
		if (port.en && port.rd)
			port.line_out <= line_mem[port.index];
	end

endmodule

//--- src/tag_compare.sv
`timescale 1ns/1ns

module tag_compare #(
	parameter int set_bits = 4
) (
	input logic [cache_pkg::addr_w-1:0] addr,
	set_port_if.decode port,
	lookup_if.driver look
);

	localparam int tag_bits = cache_pkg::addr_w - cache_pkg::offset_w - set_bits;

	logic [tag_bits-1:0] addr_tag;
	logic [tag_bits-1:0] victim_tag;
	cache_pkg::set_flags_t flags;
	logic [cache_pkg::ways-1:0] match;

	// address split: tag | index | word | byte
	assign addr_tag = addr[cache_pkg::addr_w-1 -: tag_bits];
	assign port.index = addr[cache_pkg::offset_w +: set_bits];
	assign look.word_sel = addr[cache_pkg::offset_w-1 -: cache_pkg::word_sel_w];
	assign look.tag = cache_pkg::tag_t'(addr_tag);		// high bits stay zero

	assign flags = port.flag_out;

	always_comb begin
		for (int w = 0; w < cache_pkg::ways; w++)
			match[w] = flags.way[w].valid && (flags.way[w].tag == look.tag);
	end

	assign look.hit = |match;
	assign look.hit_way = !match[0] && match[1];	// way 0 wins a double match

	assign look.victim_way = flags.lru;
	assign look.victim_dirty = flags.way[flags.lru].valid && flags.way[flags.lru].dirty;
	assign victim_tag = flags.way[flags.lru].tag[tag_bits-1:0];

	// line numbers for the memory port
	assign look.victim_line_addr = {victim_tag, port.index};
	assign look.fill_line_addr = addr[cache_pkg::addr_w-1:cache_pkg::offset_w];

endmodule

//--- src/cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
	input logic clk_50m,
	input logic rst_n,
	input logic valid,
	input logic rd,
	input logic wr,
	output logic done,
	output logic mem_valid,
	output logic mem_wr,
	output logic mem_rd,
	input logic mem_done,
	set_port_if.ctrl port,
	lookup_if.reader look,
	output logic [cache_pkg::line_addr_w-1:0] mem_addr
);

	cache_pkg::ctrl_state_e state, state_next;

	always_ff @(posedge clk_50m, negedge rst_n) begin
		if (!rst_n)
			state <= cache_pkg::st_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		done = 1'b0;
		port.en = 1'b0;
		port.rd = 1'b0;
		port.wr_data = 1'b0;
		port.wr_flag = 1'b0;
		mem_valid = 1'b0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		mem_addr = look.fill_line_addr;

		case (state)
			cache_pkg::st_idle: begin
				if (valid && (rd || wr)) begin
					port.en = 1'b1;		// read the set
					port.rd = 1'b1;
					state_next = cache_pkg::st_lookup;
				end
			end
			cache_pkg::st_lookup: begin
				if (look.hit)
					state_next = cache_pkg::st_done;
				else if (look.victim_dirty)
					state_next = cache_pkg::st_evict;
				else
					state_next = cache_pkg::st_fill;
			end
			cache_pkg::st_done: begin
				done = 1'b1;
				port.en = 1'b1;
				port.wr_flag = 1'b1;	// lru update on reads too
				port.wr_data = wr;
				state_next = cache_pkg::st_idle;
			end
			cache_pkg::st_evict: begin
				mem_valid = 1'b1;
				mem_wr = 1'b1;
				mem_addr = look.victim_line_addr;
				if (mem_done)
					state_next = cache_pkg::st_fill;
			end
			cache_pkg::st_fill: begin
				mem_valid = 1'b1;
				mem_rd = 1'b1;
				if (mem_done) begin
					port.en = 1'b1;
					port.wr_data = 1'b1;
					port.wr_flag = 1'b1;
					state_next = cache_pkg::st_reread;
				end
			end
			cache_pkg::st_reread: begin
				port.en = 1'b1;
				port.rd = 1'b1;
				state_next = cache_pkg::st_done;
			end
			default: state_next = cache_pkg::st_idle;
		endcase
	end

endmodule

//--- src/line_merge.sv
`timescale 1ns/1ns

module line_merge (
	input logic wr,
	input cache_pkg::word_t data_in,
	input logic [cache_pkg::bytes_per_word-1:0] be,
	input cache_pkg::line_u mem_rdata,
	output cache_pkg::line_u mem_wdata,
	output cache_pkg::word_t data_out,
	set_port_if.merge port,
	lookup_if.reader look
);

	cache_pkg::set_flags_t flags_old, flags_new;
	cache_pkg::set_line_t line_old, line_new;
	cache_pkg::set_be_t be_new;

	assign flags_old = port.flag_out;
	assign line_old = port.line_out;

	always_comb begin
		flags_new = flags_old;
		line_new = line_old;
		be_new = '0;

		if (look.hit) begin
			if (wr) begin
				line_new[look.hit_way].words[look.word_sel] = data_in;
				be_new[look.hit_way][look.word_sel] = be;
				flags_new.way[look.hit_way].valid = 1'b1;
				flags_new.way[look.hit_way].dirty = 1'b1;
			end
			flags_new.lru = !look.hit_way;		// other way goes next
		end else begin
			// fill the victim way, lru untouched
			line_new[look.victim_way] = mem_rdata;
			be_new[look.victim_way] = '1;
			flags_new.way[look.victim_way].valid = 1'b1;
			flags_new.way[look.victim_way].dirty = 1'b0;
			flags_new.way[look.victim_way].tag = look.tag;
		end
	end

	assign port.flag_in = flags_new;
	assign port.line_in = line_new;
	assign port.byte_en = be_new;

	assign data_out = line_old[look.hit_way].words[look.word_sel];
	assign mem_wdata = line_old[look.victim_way];		// write-back line

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ns

module dcache_top #(
	parameter int set_bits = 4
) (
	input logic clk_50m,
	input logic rst_n,

	input logic [cache_pkg::addr_w-1:0] addr,
	input cache_pkg::word_t data_in,
	input logic [cache_pkg::bytes_per_word-1:0] be,
	input logic wr,
	input logic rd,
	input logic valid,
	output cache_pkg::word_t data_out,
	output logic done,

	output logic mem_valid,
	output logic mem_wr,
	output logic mem_rd,
	output logic [cache_pkg::line_addr_w-1:0] mem_addr,
	output cache_pkg::line_u mem_wdata,
	input cache_pkg::line_u mem_rdata,
	input logic mem_done
);

	set_port_if #(.set_bits(set_bits)) set_port ();
	lookup_if look ();

	set_store #(.set_bits(set_bits)) u_store (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.port		(set_port.store)
	);

	tag_compare #(.set_bits(set_bits)) u_decode (
		.addr		(addr),
		.port		(set_port.decode),
		.look		(look.driver)
	);

	cache_ctrl u_ctrl (
		.clk_50m	(clk_50m),
		.rst_n		(rst_n),
		.valid		(valid),
		.rd			(rd),
		.wr			(wr),
		.done		(done),
		.mem_valid	(mem_valid),
		.mem_wr		(mem_wr),
		.mem_rd		(mem_rd),
		.mem_done	(mem_done),
		.port		(set_port.ctrl),
		.look		(look.reader),
		.mem_addr	(mem_addr)
	);

	line_merge u_merge (
		.wr			(wr),
		.data_in	(data_in),
		.be			(be),
		.mem_rdata	(mem_rdata),
		.mem_wdata	(mem_wdata),
		.data_out	(data_out),
		.port		(set_port.merge),
		.look		(look.reader)
	);

endmodule

//--- test/dcache_assert.sv
`timescale 1ns/1ns

module dcache_assert (
	input logic clk_50m,
	input logic rst_n,
	input logic done,
	input logic mem_valid,
	input logic mem_wr,
	input logic mem_rd,
	input logic mem_done,
	input cache_pkg::ctrl_state_e state
);

	int assert_fails = 0;

	// memory request and its direction held until the memory answers
	assert property (@(posedge clk_50m) disable iff (!rst_n)
		mem_valid && !mem_done |=> mem_valid && $stable(mem_wr) && $stable(mem_rd))
	else begin
		$error("memory request dropped or changed before mem_done");
		assert_fails++;
	end

	assert property (@(posedge clk_50m) disable iff (!rst_n) done |=> !done)
	else begin
		$error("done held longer than one cycle");
		assert_fails++;
	end

	assert property (@(posedge clk_50m) disable iff (!rst_n) !(mem_wr && mem_rd))
	else begin
		$error("mem_wr and mem_rd high together");
		assert_fails++;
	end

	// memory answers only a live request
	assert property (@(posedge clk_50m) disable iff (!rst_n)
		mem_done |-> state inside {cache_pkg::st_evict, cache_pkg::st_fill})
	else begin
		$error("mem_done outside a memory phase");
		assert_fails++;
	end

endmodule

bind cache_ctrl dcache_assert u_assert (.*);

//--- test/dcache_checker.sv
`timescale 1ns/1ns

module dcache_checker #(
	parameter int set_bits = 4
) (
	input logic clk_50m,
	input logic rst_n,
	input logic [cache_pkg::addr_w-1:0] addr,
	input cache_pkg::word_t data_in,
	input logic [cache_pkg::bytes_per_word-1:0] be,
	input logic wr,
	input logic rd,
	input logic valid,
	input cache_pkg::word_t data_out,
	input logic done,
	input logic mem_valid,
	input logic mem_wr,
	input logic mem_rd,
	input logic [cache_pkg::line_addr_w-1:0] mem_addr,
	input cache_pkg::line_u mem_wdata,
	input cache_pkg::line_u mem_rdata,
	input logic mem_done
);

	localparam int sets = 2 ** set_bits;

	logic [7:0] shadow [logic [31:0]];		// byte address -> written byte
	logic [cache_pkg::line_addr_w-1:0] way_line [sets][2];
	logic way_valid [sets][2];
	logic way_dirty [sets][2];
	logic lru [sets];
	logic [cache_pkg::line_addr_w-1:0] evict_line;
	logic busy = 1'b0;
	logic exp_hit, exp_evict, saw_evict, saw_fill, saw_mem;
	int edges;
	int errs_at_accept;
	int tests = 0;
	int error_count = 0;

	function automatic logic [7:0] byte_at(input logic [31:0] a);
		logic [31:0] word_idx;
		word_idx = a >> 2;		// untouched memory holds its word index
		if (shadow.exists(a))
			return shadow[a];
		return word_idx[8*a[1:0] +: 8];
	endfunction

	function automatic cache_pkg::word_t shadow_word(input logic [31:0] a);
		cache_pkg::word_t w;
		for (int b = 0; b < 4; b++)
			w[8*b +: 8] = byte_at({a[31:2], 2'(b)});
		return w;
	endfunction

	// beat 0 is the high half of word 0
	function automatic logic [15:0] shadow_beat(input logic [27:0] line, input int k);
		cache_pkg::word_t w;
		w = shadow_word({line, 4'h0} + 32'(4 * (k / 2)));
		return (k % 2 == 0) ? w[31:16] : w[15:0];
	endfunction

	task automatic report_fail(input string msg);
		error_count++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	// tag model, updated when the request is accepted
	task automatic accept_request();
		logic [cache_pkg::line_addr_w-1:0] la;
		int s;
		int v;
		la = addr[31:4];
		s = la % sets;
		v = lru[s];
		exp_hit = 1'b0;
		exp_evict = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (!exp_hit && way_valid[s][w] && way_line[s][w] == la) begin
				exp_hit = 1'b1;
				v = w;
			end
		end
		if (!exp_hit) begin
			exp_evict = way_valid[s][v] && way_dirty[s][v];
			evict_line = way_line[s][v];
			way_line[s][v] = la;
			way_valid[s][v] = 1'b1;
			way_dirty[s][v] = 1'b0;
		end
		lru[s] = (v == 0);
		if (wr)
			way_dirty[s][v] = 1'b1;
		busy = 1'b1;
		edges = 0;
		saw_evict = 1'b0;
		saw_fill = 1'b0;
		saw_mem = 1'b0;
		errs_at_accept = error_count;
	endtask

	task automatic check_memory();
		logic [15:0] beat;
		if (mem_wr) begin
			saw_evict = 1'b1;
			if (!exp_evict || mem_addr != evict_line)
				report_fail($sformatf("unexpected write-back of line %h", mem_addr));
			for (int k = 0; k < 8; k++) begin
				beat = shadow_beat(mem_addr, k);
				if (mem_wdata.beats[k] !== beat)
					report_fail($sformatf("write-back beat %0d is %h, expected %h",
						k, mem_wdata.beats[k], beat));
			end
		end else begin
			saw_fill = 1'b1;
			if (mem_addr != addr[31:4])
				report_fail($sformatf("fill of line %h, expected %h", mem_addr, addr[31:4]));
			for (int k = 0; k < 8; k++) begin
				beat = shadow_beat(mem_addr, k);
				if (mem_rdata.beats[k] !== beat)
					report_fail($sformatf("fill beat %0d is %h, expected %h",
						k, mem_rdata.beats[k], beat));
			end
		end
	endtask

	task automatic finish_request();
		cache_pkg::word_t exp;
		exp = shadow_word(addr);
		if (rd && data_out !== exp)
			report_fail($sformatf("read %h returned %h, expected %h", addr, data_out, exp));
		if (wr) begin
			for (int b = 0; b < 4; b++)
				if (be[b])
					shadow[{addr[31:2], 2'(b)}] = data_in[8*b +: 8];
		end
		if (exp_hit && (edges != 2 || saw_mem))
			report_fail($sformatf("hit on %h took %0d edges", addr, edges));
		if (!exp_hit && (!saw_fill || saw_evict != exp_evict))
			report_fail($sformatf("miss on %h: fill %0b, write-back %0b, expected %0b",
				addr, saw_fill, saw_evict, exp_evict));
		tests++;
		$display("test %0d: %s %h %s", tests, wr ? "write" : "read", addr,
			error_count == errs_at_accept ? "ok" : "mismatch");
		busy = 1'b0;
	endtask

	always @(negedge clk_50m) begin
		if (!rst_n) begin
			if (done || mem_valid || mem_wr || mem_rd)
				report_fail("handshake output high during reset");
			for (int s = 0; s < sets; s++) begin
				way_valid[s][0] = 1'b0;
				way_valid[s][1] = 1'b0;
				lru[s] = 1'b0;
			end
			busy = 1'b0;
		end else if (!busy) begin
			if (done || mem_valid || mem_wr || mem_rd)
				report_fail("handshake output high with no request in flight");
			if (valid && (rd || wr))
				accept_request();
		end else begin
			edges++;
			if (mem_valid)
				saw_mem = 1'b1;
			if (mem_valid && mem_done)
				check_memory();
			if (done)
				finish_request();
		end
	end

	task print_summary();
		$display("%0d tests, %0d errors", tests, error_count);
	endtask

endmodule

//--- test/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;

	localparam int set_bits = 4;
	localparam int done_timeout = 200;

	logic clk_50m = 1'b0;
	logic rst_n;
	logic [cache_pkg::addr_w-1:0] addr;
	cache_pkg::word_t data_in;
	cache_pkg::word_t data_out;
	logic [cache_pkg::bytes_per_word-1:0] be;
	logic wr;
	logic rd;
	logic valid;
	logic done;
	logic mem_valid;
	logic mem_wr;
	logic mem_rd;
	logic mem_done;
	logic [cache_pkg::line_addr_w-1:0] mem_addr;
	cache_pkg::line_u mem_wdata;
	cache_pkg::line_u mem_rdata;

	cache_pkg::line_u mem_lines [logic [cache_pkg::line_addr_w-1:0]];
	int mem_wait = 0;
	logic [31:0] last_addr = '0;

	always #10 clk_50m = ~clk_50m;

	dcache_top #(.set_bits(set_bits)) UUT (.*);

	dcache_checker #(.set_bits(set_bits)) check (.*);

	// each word of untouched memory holds its word index
	function automatic cache_pkg::line_u pattern_line(input logic [27:0] line_addr);
		cache_pkg::line_u line;
		logic [31:0] word;
		for (int k = 0; k < 8; k++) begin
			word = {line_addr, 2'(k / 2)};
			line.beats[k] = (k % 2 == 0) ? word[31:16] : word[15:0];
		end
		return line;
	endfunction

	always @(posedge clk_50m) begin : memory_model
		#2;
		mem_done = 1'b0;
		if (rst_n && mem_valid) begin
			if (mem_wait == 0)
				mem_wait = $urandom_range(1, 6);
			mem_wait = mem_wait - 1;
			if (mem_wait == 0) begin
				if (mem_wr)
					mem_lines[mem_addr] = mem_wdata;
				else if (mem_lines.exists(mem_addr))
					mem_rdata = mem_lines[mem_addr];
				else
					mem_rdata = pattern_line(mem_addr);
				mem_done = 1'b1;
			end
		end
	end

	// called 2 ns after a rising edge, returns at the same point
	task automatic run_access(input logic is_wr, input logic [31:0] a,
		input logic [31:0] d, input logic [3:0] b);
		int cycles;
		addr = a;
		data_in = d;
		be = b;
		wr = is_wr;
		rd = !is_wr;
		valid = 1'b1;
		last_addr = a;
		cycles = 0;
		do begin
			@(negedge clk_50m);
			cycles++;
		end while (!done && cycles < done_timeout);
		if (!done) begin
			$display("timeout: no done within %0d cycles for access to %h", cycles, a);
			$display("TEST FAILED");
			$finish;
		end else begin
			@(posedge clk_50m);
			#2;
			valid = 1'b0;
			wr = 1'b0;
			rd = 1'b0;
		end
	endtask

	initial begin
		logic [31:0] a;
		rst_n = 1'b0;
		valid = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		addr = '0;
		data_in = '0;
		be = '0;
		mem_done = 1'b0;
		mem_rdata = '0;
		void'($urandom(58));
		repeat (8) @(posedge clk_50m);
		#2;
		rst_n = 1'b1;
		@(posedge clk_50m);
		#2;

		// set 3: A, dirty B, A again, then C must push B out
		run_access(1'b1, 32'h0050_0030, 32'h1111_2222, 4'hf);
		run_access(1'b1, 32'h0051_0034, 32'h3333_4444, 4'h5);
		run_access(1'b0, 32'h0050_0030, '0, '0);
		run_access(1'b0, 32'h0052_0038, '0, '0);
		run_access(1'b0, 32'h0051_0034, '0, '0);

		for (int i = 0; i < 300; i++) begin
			if ($urandom_range(0, 3) == 0)
				a = last_addr;
			else
				a = 32'h0040_0000 + $urandom_range(0, 3) * 32'h1000
					+ $urandom_range(0, 2) * 32'h10 + $urandom_range(0, 3) * 4;
			run_access(1'($urandom_range(0, 1)), a, $urandom, 4'($urandom));
		end

		check.print_summary();
		if (check.error_count == 0 && UUT.u_ctrl.u_assert.assert_fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- filelist.f
src/cache_pkg.sv
src/set_port_if.sv
src/lookup_if.sv
src/set_store.sv
src/tag_compare.sv
src/cache_ctrl.sv
src/line_merge.sv
src/dcache_top.sv
test/dcache_assert.sv
test/dcache_checker.sv
test/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - src/cache_pkg.sv
      - src/set_port_if.sv
      - src/lookup_if.sv
      - src/set_store.sv
      - src/tag_compare.sv
      - src/cache_ctrl.sv
      - src/line_merge.sv
      - src/dcache_top.sv
  - target: test
    files:
      - test/dcache_assert.sv
      - test/dcache_checker.sv
      - test/tb_dcache.sv
